// File: unpack_cfg.svh
// configuration macros for lane count, data, address and tag widths, and bank depth
`ifndef UNPACK_CFG_SVH
`define UNPACK_CFG_SVH

// number of lanes carried by one batch command
`define SCT_NUM_LANES 4

// width of one data word stored in a bank
`define SCT_DATA_W 16

// bank word address width
`define SCT_ADDR_W 4

// batch sequence tag width, the tag wraps at 2**SCT_TAG_W
`define SCT_TAG_W 4

// words per bank, has to cover the full address range
`define SCT_BANK_DEPTH 16

`endif

// File: lane_pkg.sv
// lane-side types: address and word vectors, lane request, item and response structs, bank FSM
`include "unpack_cfg.svh"

package lane_pkg;

    // word address inside one bank
    typedef logic [`SCT_ADDR_W-1:0] addr_t;

    // data word, the accumulation wraps at this width
    typedef logic [`SCT_DATA_W-1:0] word_t;

    // one lane's slot of a batch command
    typedef struct packed {
        addr_t addr;
        word_t data;
    } lane_req_t;

    // what travels from the unpacker to a bank
    typedef struct packed {
        lane_req_t              req;
        logic [`SCT_TAG_W-1:0]  tag;
    } lane_item_t;

    // bank response, the updated word with the batch tag
    typedef struct packed {
        word_t                  word;
        logic [`SCT_TAG_W-1:0]  tag;
    } lane_rsp_t;

    typedef enum logic {
        BANK_IDLE,
        BANK_RESP
    } bank_state_t;

endpackage

// File: batch_pkg.sv
// issue-side types: tag, lane mask, external batch command and tagged batch
`include "unpack_cfg.svh"

package batch_pkg;

    // sequence number stamped on every accepted command
    typedef logic [`SCT_TAG_W-1:0] tag_t;

    // one bit per lane, a set bit means the lane takes part in the batch
    typedef logic [`SCT_NUM_LANES-1:0] lane_mask_t;

    // command as it arrives from outside
    typedef struct packed {
        lane_mask_t                                 mask;
        lane_pkg::lane_req_t [`SCT_NUM_LANES-1:0]   lanes;
    } batch_cmd_t;

    // command after the issuer has stamped it
    typedef struct packed {
        batch_cmd_t cmd;
        tag_t       tag;
    } batch_t;

endpackage

// File: batch_issuer.sv
// batch_issuer: one-entry command register with a wrapping sequence tag
`timescale 1ns/1ps

module batch_issuer (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    cmd_valid,
    input  batch_pkg::batch_cmd_t   cmd,
    output logic                    cmd_ready,
    output logic                    batch_valid,
    output batch_pkg::batch_t       batch,
    input  logic                    batch_ready
);

    batch_pkg::tag_t next_tag;
    logic            cmd_fire;

    // the single entry can be refilled in the cycle it is drained
    assign cmd_ready = !batch_valid || batch_ready;
    assign cmd_fire  = cmd_valid && cmd_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            batch_valid <= 1'b0;
            next_tag    <= '0;
        end else begin
            if (cmd_fire) begin
                batch_valid <= 1'b1;
                // empty-mask commands take a tag as well
                next_tag    <= batch_pkg::tag_t'(next_tag + 1'b1);
            end else if (batch_ready) begin
                batch_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_fire) begin
            batch.cmd <= cmd;
            batch.tag <= next_tag;
        end
    end

endmodule

// File: elastic_buffer.sv
// elastic_buffer: two-entry valid/ready buffer with registered output and registered ready
`timescale 1ns/1ps

module elastic_buffer #(
    parameter int DATAW = 8
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             valid_in,
    input  logic [DATAW-1:0] data_in,
    output logic             ready_in,
    output logic             valid_out,
    output logic [DATAW-1:0] data_out,
    input  logic             ready_out
);

    // out_* is the output register, skid_* catches one item while the output stalls
    logic             out_valid;
    logic [DATAW-1:0] out_data;
    logic             skid_valid;
    logic [DATAW-1:0] skid_data;
    logic             out_free;

    // the output register can load when it is empty or being read this cycle
    assign out_free  = !out_valid || ready_out;

    // ready only looks at the skid slot, so there is no path from ready_out
    assign ready_in  = !skid_valid;
    assign valid_out = out_valid;
    assign data_out  = out_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end else begin
            if (out_free) begin
                if (skid_valid) begin
                    out_valid  <= 1'b1;
                    skid_valid <= 1'b0;
                end else begin
                    out_valid  <= valid_in;
                end
            end else if (valid_in && !skid_valid) begin
                skid_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (out_free) begin
            out_data <= skid_valid ? skid_data : data_in;
        end else if (valid_in && !skid_valid) begin
            skid_data <= data_in;
        end
    end

endmodule

// File: stream_unpack.sv
// stream_unpack: splits a masked batch into per-lane streams, one elastic buffer per lane
`timescale 1ns/1ps
`include "unpack_cfg.svh"

module stream_unpack (
    input  logic                                        clk,
    input  logic                                        reset,
    input  logic                                        batch_valid,
    input  batch_pkg::batch_t                           batch,
    output logic                                        batch_ready,
    output logic [`SCT_NUM_LANES-1:0]                   lane_valid,
    output lane_pkg::lane_item_t [`SCT_NUM_LANES-1:0]   lane_item,
    input  logic [`SCT_NUM_LANES-1:0]                   lane_ready
);

    // lanes of the current batch that have not yet gone into their buffer
    batch_pkg::lane_mask_t rem_mask;
    batch_pkg::lane_mask_t rem_mask_n;
    batch_pkg::lane_mask_t buf_ready;
    batch_pkg::lane_mask_t push;
    logic                  sent_all;

    // a lane whose buffer takes the item this cycle drops out of the remaining set
    assign rem_mask_n = rem_mask & ~buf_ready;
    assign sent_all   = ~(|(batch.cmd.mask & rem_mask_n));

    // an empty mask is released in the cycle it shows up
    assign batch_ready = sent_all;

    always_ff @(posedge clk) begin
        if (reset) begin
            rem_mask <= '1;
        end else if (batch_valid) begin
            if (sent_all) begin
                rem_mask <= '1;
            end else begin
                rem_mask <= rem_mask_n;
            end
        end
    end

    for (genvar i = 0; i < `SCT_NUM_LANES; i++) begin : g_lane
        lane_pkg::lane_item_t item_in;

        assign item_in.req = batch.cmd.lanes[i];
        assign item_in.tag = batch.tag;

        // offer only masked lanes that were not sent in an earlier cycle
        assign push[i] = batch_valid && batch.cmd.mask[i] && rem_mask[i];

        elastic_buffer #(
            .DATAW ($bits(lane_pkg::lane_item_t))
        ) i_elastic_buffer (
            .clk       (clk),
            .reset     (reset),
            .valid_in  (push[i]),
            .data_in   (item_in),
            .ready_in  (buf_ready[i]),
            .valid_out (lane_valid[i]),
            .data_out  (lane_item[i]),
            .ready_out (lane_ready[i])
        );
    end

endmodule

// File: lane_bank.sv
// lane_bank: per-lane accumulating memory with a tagged registered response
`timescale 1ns/1ps
`include "unpack_cfg.svh"

module lane_bank (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 req_valid,
    input  lane_pkg::lane_item_t req,
    output logic                 req_ready,
    output logic                 rsp_valid,
    output lane_pkg::lane_rsp_t  rsp,
    input  logic                 rsp_ready
);

    lane_pkg::bank_state_t state;
    lane_pkg::word_t       mem [`SCT_BANK_DEPTH];
    lane_pkg::word_t       new_word;
    logic                  req_fire;

    // a pending response that leaves this cycle frees the bank for the next request
    assign req_ready = (state == lane_pkg::BANK_IDLE) || rsp_ready;
    assign req_fire  = req_valid && req_ready;
    assign rsp_valid = (state == lane_pkg::BANK_RESP);

    // read-modify-write in one cycle, the sum wraps at the word width
    assign new_word = mem[req.req.addr] + req.req.data;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= lane_pkg::BANK_IDLE;
        end else begin
            case (state)
                lane_pkg::BANK_IDLE: begin
                    if (req_valid) begin
                        state <= lane_pkg::BANK_RESP;
                    end
                end
                lane_pkg::BANK_RESP: begin
                    // stay here when the next request replaces the outgoing response
                    if (rsp_ready && !req_valid) begin
                        state <= lane_pkg::BANK_IDLE;
                    end
                end
                default: begin
                    state <= lane_pkg::BANK_IDLE;
                end
            endcase
        end
    end

    // memory starts from zero so the accumulated words are known
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `SCT_BANK_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (req_fire) begin
            mem[req.req.addr] <= new_word;
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            rsp.word <= new_word;
            rsp.tag  <= req.tag;
        end
    end

endmodule

// File: scatter_top.sv
// scatter_top: issuer, unpacker and one accumulating bank per lane
`timescale 1ns/1ps
`include "unpack_cfg.svh"

module scatter_top (
    input  logic                                        clk,
    input  logic                                        reset,
    input  logic                                        cmd_valid,
    input  batch_pkg::batch_cmd_t                       cmd,
    output logic                                        cmd_ready,
    output logic [`SCT_NUM_LANES-1:0]                   rsp_valid,
    output lane_pkg::lane_rsp_t [`SCT_NUM_LANES-1:0]    rsp,
    input  logic [`SCT_NUM_LANES-1:0]                   rsp_ready
);

    logic                                       batch_valid;
    logic                                       batch_ready;
    batch_pkg::batch_t                          batch;
    logic [`SCT_NUM_LANES-1:0]                  lane_valid;
    logic [`SCT_NUM_LANES-1:0]                  lane_ready;
    lane_pkg::lane_item_t [`SCT_NUM_LANES-1:0]  lane_item;

    batch_issuer i_batch_issuer (
        .clk         (clk),
        .reset       (reset),
        .cmd_valid   (cmd_valid),
        .cmd         (cmd),
        .cmd_ready   (cmd_ready),
        .batch_valid (batch_valid),
        .batch       (batch),
        .batch_ready (batch_ready)
    );

    stream_unpack i_stream_unpack (
        .clk         (clk),
        .reset       (reset),
        .batch_valid (batch_valid),
        .batch       (batch),
        .batch_ready (batch_ready),
        .lane_valid  (lane_valid),
        .lane_item   (lane_item),
        .lane_ready  (lane_ready)
    );

    // lanes are independent, each bank only sees its own stream
    for (genvar i = 0; i < `SCT_NUM_LANES; i++) begin : g_bank
        lane_bank i_lane_bank (
            .clk       (clk),
            .reset     (reset),
            .req_valid (lane_valid[i]),
            .req       (lane_item[i]),
            .req_ready (lane_ready[i]),
            .rsp_valid (rsp_valid[i]),
            .rsp       (rsp[i]),
            .rsp_ready (rsp_ready[i])
        );
    end

endmodule

// File: tb_clock_gen.sv
// tb_clock_gen: 20 ns testbench clock and a synchronous reset held for 16 cycles
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // reset drops just after the 16th rising edge, like any other driven input
    initial begin
        reset = 1'b1;
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
    end

endmodule

// File: scatter_properties.sv
// bound assertions on the held batch, single lane pushes and held responses
`timescale 1ns/1ps
`include "unpack_cfg.svh"

module scatter_properties (
    input  logic                                        clk,
    input  logic                                        reset,
    input  logic                                        batch_valid,
    input  logic                                        batch_ready,
    input  batch_pkg::batch_t                           batch,
    input  logic [`SCT_NUM_LANES-1:0]                   push,
    input  logic [`SCT_NUM_LANES-1:0]                   buf_ready,
    input  logic [`SCT_NUM_LANES-1:0]                   rsp_valid,
    input  lane_pkg::lane_rsp_t [`SCT_NUM_LANES-1:0]    rsp,
    input  logic [`SCT_NUM_LANES-1:0]                   rsp_ready
);

    // the issuer must not touch a batch that the unpacker has not released
    a_batch_held: assert property (@(posedge clk) disable iff (reset)
        batch_valid && !batch_ready |=> batch_valid && $stable(batch))
        else $error("batch changed while batch_ready was low");

    // a lane taken by its buffer is not offered again until the batch is released
    for (genvar i = 0; i < `SCT_NUM_LANES; i++) begin : g_push
        a_push_once: assert property (@(posedge clk) disable iff (reset)
            push[i] && buf_ready[i] && !batch_ready |=> !push[i])
            else $error("lane %0d was pushed twice for one batch", i);
    end

    for (genvar i = 0; i < `SCT_NUM_LANES; i++) begin : g_rsp
        a_rsp_held: assert property (@(posedge clk) disable iff (reset)
            rsp_valid[i] && !rsp_ready[i] |=> rsp_valid[i] && $stable(rsp[i]))
            else $error("response on lane %0d changed while stalled", i);
    end

endmodule

// File: scatter_tb.sv
// testbench top with a stimulus table, a per-lane reference memory and response checks
`timescale 1ns/1ps
`include "unpack_cfg.svh"

module scatter_tb;

    localparam int NL      = `SCT_NUM_LANES;
    localparam int NROWS   = 12;
    localparam int TIMEOUT = 200;

    typedef enum logic [1:0] {
        BP_READY,
        BP_RANDOM,
        BP_STALL
    } bp_mode_t;

    // one stimulus row with lane 3 as the leftmost element of addr and val
    typedef struct packed {
        logic [NL-1:0]              mask;
        lane_pkg::addr_t [NL-1:0]   addr;
        lane_pkg::word_t [NL-1:0]   val;
        bp_mode_t                   mode;
        logic [4:0]                 count;
    } test_row_t;

    logic                           clk;
    logic                           reset;
    logic                           cmd_valid;
    batch_pkg::batch_cmd_t          cmd;
    logic                           cmd_ready;
    logic [NL-1:0]                  rsp_valid;
    lane_pkg::lane_rsp_t [NL-1:0]   rsp;
    logic [NL-1:0]                  rsp_ready;

    test_row_t              rows [NROWS];
    lane_pkg::word_t        model_mem [NL][`SCT_BANK_DEPTH];
    lane_pkg::lane_rsp_t    exp_q [NL][$];
    bp_mode_t               bp_mode;
    logic                   stall_on;
    logic                   saw_stall;
    logic                   timed_out;
    int                     seed = 65562;
    int                     batch_count;
    int                     errors;

    tb_clock_gen i_tb_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    scatter_top i_scatter_top (
        .clk       (clk),
        .reset     (reset),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .cmd_ready (cmd_ready),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .rsp_ready (rsp_ready)
    );

    bind stream_unpack scatter_properties i_unpack_checks (
        .clk         (clk),
        .reset       (reset),
        .batch_valid (batch_valid),
        .batch_ready (batch_ready),
        .batch       (batch),
        .push        (push),
        .buf_ready   (buf_ready),
        .rsp_valid   ('0),
        .rsp         ('0),
        .rsp_ready   ('0)
    );

    bind scatter_top scatter_properties i_top_checks (
        .clk         (clk),
        .reset       (reset),
        .batch_valid (batch_valid),
        .batch_ready (batch_ready),
        .batch       (batch),
        .push        ('0),
        .buf_ready   ('0),
        .rsp_valid   (rsp_valid),
        .rsp         (rsp),
        .rsp_ready   (rsp_ready)
    );

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            errors++;
        end
    endtask

    // every lane draws from $random each cycle and the sequence depends only on the seed
    always @(posedge clk) begin : drive_rsp_ready
        int rnd;
        #1;
        for (int l = 0; l < NL; l++) begin
            rnd = $random(seed);
            case (bp_mode)
                BP_RANDOM: rsp_ready[l] = rnd[0];
                BP_STALL:  rsp_ready[l] = !(stall_on && l == 0);
                default:   rsp_ready[l] = 1'b1;
            endcase
        end
    end

    // valid and ready high here means the response is taken at the next rising edge
    always @(negedge clk) begin : watch_responses
        lane_pkg::lane_rsp_t expd;
        if (!reset) begin
            for (int l = 0; l < NL; l++) begin
                if (rsp_valid[l] && rsp_ready[l]) begin
                    if (exp_q[l].size() == 0) begin
                        $display("lane %0d returned a response that no command asked for", l);
                        errors++;
                    end else begin
                        expd = exp_q[l].pop_front();
                        check_value($sformatf("rsp[%0d].word", l), 32'(rsp[l].word),
                                    32'(expd.word));
                        check_value($sformatf("rsp[%0d].tag", l), 32'(rsp[l].tag),
                                    32'(expd.tag));
                    end
                end
            end
        end
    end

    // the reference model advances at the command transfer and includes empty masks
    task automatic record_accept(input test_row_t row);
        lane_pkg::lane_rsp_t item;
        for (int l = 0; l < NL; l++) begin
            if (row.mask[l]) begin
                item.word = model_mem[l][row.addr[l]] + row.val[l];
                item.tag  = batch_pkg::tag_t'(batch_count % 16);
                model_mem[l][row.addr[l]] = item.word;
                exp_q[l].push_back(item);
            end
        end
        batch_count++;
    endtask

    task automatic send_cmd(input int t, input test_row_t row);
        int waited;
        cmd_valid = 1'b1;
        cmd.mask  = row.mask;
        for (int l = 0; l < NL; l++) begin
            cmd.lanes[l].addr = row.addr[l];
            cmd.lanes[l].data = row.val[l];
        end
        waited = 0;
        @(negedge clk);
        while (!cmd_ready && waited < TIMEOUT) begin
            // lane 0 is let go once its back-pressure has reached the command port
            if (stall_on && waited >= 8) begin
                saw_stall = 1'b1;
                stall_on  = 1'b0;
            end
            waited++;
            @(negedge clk);
        end
        if (cmd_ready) begin
            record_accept(row);
        end else begin
            $display("test %0d: cmd_ready stayed low for %0d cycles", t, TIMEOUT);
            timed_out = 1'b1;
        end
        @(posedge clk);
        #1;
        cmd_valid = 1'b0;
    endtask

    function automatic int first_busy_lane();
        for (int l = 0; l < NL; l++) begin
            if (exp_q[l].size() != 0) begin
                return l;
            end
        end
        return -1;
    endfunction

    task automatic wait_drain(input int t);
        int waited;
        int busy;
        waited = 0;
        busy   = first_busy_lane();
        while (busy >= 0 && waited < TIMEOUT) begin
            @(posedge clk);
            #1;
            waited++;
            busy = first_busy_lane();
        end
        if (busy >= 0) begin
            $display("test %0d: lane %0d still waits for a response after %0d cycles",
                     t, busy, TIMEOUT);
            timed_out = 1'b1;
        end
    endtask

    initial begin : run_tests
        int waited;
        int errors_before;
        int tests_bad;
        cmd_valid   = 1'b0;
        cmd         = '0;
        rsp_ready   = '1;
        bp_mode     = BP_READY;
        stall_on    = 1'b0;
        saw_stall   = 1'b0;
        timed_out   = 1'b0;
        batch_count = 0;
        errors      = 0;
        tests_bad   = 0;
        for (int l = 0; l < NL; l++) begin
            for (int a = 0; a < `SCT_BANK_DEPTH; a++) begin
                model_mem[l][a] = '0;
            end
        end

        // mask, addresses, values, back-pressure mode and number of batches
        rows[0]  = '{4'hf, {4'h3, 4'h2, 4'h1, 4'h0},
                     {16'h0011, 16'h0022, 16'h0033, 16'h0044}, BP_READY, 5'd1};
        rows[1]  = '{4'hf, {4'h3, 4'h2, 4'h1, 4'h0},
                     {16'h1000, 16'h2000, 16'h3000, 16'h4000}, BP_READY, 5'd2};
        // lanes 1 and 3 sit on addresses that the next row writes on those lanes
        rows[2]  = '{4'h5, {4'h8, 4'h7, 4'ha, 4'h7},
                     {16'h00aa, 16'h00bb, 16'h00cc, 16'h00dd}, BP_READY, 5'd1};
        rows[3]  = '{4'ha, {4'h8, 4'h9, 4'ha, 4'hb},
                     {16'h0101, 16'h0202, 16'h0303, 16'h0404}, BP_READY, 5'd1};
        rows[4]  = '{4'h0, {4'h1, 4'h1, 4'h1, 4'h1},
                     {16'h5555, 16'h5555, 16'h5555, 16'h5555}, BP_READY, 5'd1};
        rows[5]  = '{4'hf, {4'hc, 4'hd, 4'he, 4'hf},
                     {16'hffff, 16'h8000, 16'h7fff, 16'h0001}, BP_READY, 5'd2};
        rows[6]  = '{4'hf, {4'h1, 4'h1, 4'h2, 4'h2},
                     {16'h0005, 16'h0006, 16'h0007, 16'h0008}, BP_RANDOM, 5'd6};
        rows[7]  = '{4'h3, {4'h4, 4'h5, 4'h4, 4'h5},
                     {16'h0010, 16'h0020, 16'h0030, 16'h0040}, BP_RANDOM, 5'd4};
        rows[8]  = '{4'h0, {4'h0, 4'h0, 4'h0, 4'h0},
                     {16'h0000, 16'h0000, 16'h0000, 16'h0000}, BP_READY, 5'd3};
        rows[9]  = '{4'h9, {4'h0, 4'hf, 4'h0, 4'hf},
                     {16'h0123, 16'h0456, 16'h0789, 16'h0abc}, BP_READY, 5'd17};
        rows[10] = '{4'hf, {4'h2, 4'h3, 4'h4, 4'h5},
                     {16'h0e01, 16'h0e02, 16'h0e03, 16'h0e04}, BP_STALL, 5'd6};
        rows[11] = '{4'h6, {4'ha, 4'hb, 4'hc, 4'hd},
                     {16'hbeef, 16'h1234, 16'h4321, 16'h0f0f}, BP_RANDOM, 5'd5};

        waited = 0;
        @(negedge clk);
        while (reset && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (reset) begin
            $display("reset never went low");
            timed_out = 1'b1;
        end
        check_value("cmd_ready", 32'(cmd_ready), 32'd1);
        check_value("rsp_valid", 32'(rsp_valid), 32'd0);
        $display("test reset: %s", (errors == 0) ? "ok" : "errors");

        for (int t = 0; t < NROWS && !timed_out; t++) begin
            errors_before = errors;
            bp_mode       = rows[t].mode;
            stall_on      = (rows[t].mode == BP_STALL);
            saw_stall     = 1'b0;
            @(posedge clk);
            #1;
            for (int n = 0; n < int'(rows[t].count) && !timed_out; n++) begin
                send_cmd(t, rows[t]);
            end
            if (!timed_out) begin
                wait_drain(t);
            end
            if (rows[t].mode == BP_STALL && !saw_stall) begin
                $display("test %0d: cmd_ready never dropped while lane 0 was stalled", t);
                errors++;
            end
            if (errors != errors_before || timed_out) begin
                tests_bad++;
            end
            $display("test %0d: %s", t,
                     (errors == errors_before && !timed_out) ? "ok" : "errors");
            @(negedge clk);
        end

        // a few idle cycles so that a stray response still reaches the monitor
        repeat (10) @(posedge clk);
        $display("summary: %0d rows, %0d with errors, %0d check errors, %0d batches sent",
                 NROWS, tests_bad, errors, batch_count);
        if (errors == 0 && !timed_out) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: build.f
+incdir+.
lane_pkg.sv
batch_pkg.sv
batch_issuer.sv
elastic_buffer.sv
stream_unpack.sv
lane_bank.sv
scatter_top.sv
tb_clock_gen.sv
scatter_properties.sv
scatter_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module scatter_tb -f build.f -o scatter_sim

output=$(./obj_dir/scatter_sim) || true
echo "$output"

if grep -q "all tests passed" <<< "$output"; then
    exit 0
fi
exit 1
